// File: logic/heapMemory_defs.svh
//----------------------------------------------------------
// Size macros for the heap of fixed-size arrays
// Handle, index, element and opcode widths, and the counts
// and bus address width derived from them
//----------------------------------------------------------
`ifndef HEAP_MEMORY_DEFS_SVH
`define HEAP_MEMORY_DEFS_SVH

`define HEAP_ARRAY_BITS 2                                  // Bits of an array handle
`define HEAP_INDEX_BITS 3                                  // Bits of an element index
`define HEAP_DATA_BITS 12                                  // Element width
`define HEAP_OP_BITS 4                                     // Opcode width

// Derived sizes
`define HEAP_ARRAY_COUNT (1 << `HEAP_ARRAY_BITS)           // Number of arrays
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)          // Elements per array

// Bus address is opcode, then handle, then index
`define HEAP_ADR_BITS (`HEAP_OP_BITS + `HEAP_ARRAY_BITS + `HEAP_INDEX_BITS)

`endif

// File: logic/heapPkg.sv
//----------------------------------------------------------
// Shared types of the heap memory
// Opcodes, error codes, request and result words, size clear
//----------------------------------------------------------
`include "heapMemory_defs.svh"

package heapPkg;

  // Operation selected by the top bits of the bus address
  typedef enum logic [`HEAP_OP_BITS-1:0] {
    opClear,                                               // Drop every allocation
    opAlloc,                                               // New array handle
    opFree,                                                // Return a handle
    opWrite,                                               // Store an element
    opRead,                                                // Fetch an element
    opSize,                                                // Current size
    opPush,                                                // Append at the end
    opPop,                                                 // Remove from the end
    opIndexOf,                                             // Last match plus one
    opAdd                                                  // Add and return new value
  } heapOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapErr;

  //----------------------------------------------------------
  // Words passed between the units
  //----------------------------------------------------------
  typedef struct packed {
    logic                        valid;                    // One cycle per bus transfer
    heapOp                       op;
    logic [`HEAP_ARRAY_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0] index;
    logic [`HEAP_DATA_BITS-1:0]  value;                    // Operand from the bus
  } heapRequest;

  typedef struct packed {
    heapErr                     err;
    logic                       spare;                     // Always zero
    logic [`HEAP_DATA_BITS-1:0] value;
  } heapResult;                                            // Same layout as the bus read word

  typedef struct packed {
    logic                        enable;
    logic                        all;                      // Zero every size, not just one
    logic [`HEAP_ARRAY_BITS-1:0] array;
  } sizeClear;

endpackage

// File: logic/wbHeapPort.sv
//----------------------------------------------------------
// Wishbone classic slave of the heap memory
// One request pulse per bus cycle, ack with the result
//----------------------------------------------------------
`timescale 1ns/1ns
`include "heapMemory_defs.svh"

module wbHeapPort (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,                   // Opcode decides, so not decoded
  input  logic [`HEAP_ADR_BITS-1:0]  adr,
  input  logic [`HEAP_DATA_BITS-1:0] writeData,
  input  heapPkg::heapResult         allocResult,
  input  heapPkg::heapResult         storeResult,
  input  logic                       allocDone,
  input  logic                       storeDone,
  output heapPkg::heapRequest        request,
  output logic                       ack,
  output heapPkg::heapResult         readData
);

  logic                        busy;                       // Transfer outstanding
  logic                        reqValid;
  logic                        start;
  logic                        done;
  heapPkg::heapOp              reqOp;
  logic [`HEAP_ARRAY_BITS-1:0] reqArray;
  logic [`HEAP_INDEX_BITS-1:0] reqIndex;
  logic [`HEAP_DATA_BITS-1:0]  reqValue;

  assign start = cyc && stb && !ack && !busy;              // Wait until ack has fallen
  assign done  = allocDone || storeDone;

  assign request = '{valid: reqValid, op: reqOp, array: reqArray,
                     index: reqIndex, value: reqValue};

  //----------------------------------------------------------
  // Handshake state
  //----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      busy     <= 1'b0;
      reqValid <= 1'b0;
      ack      <= 1'b0;
      readData <= '0;
    end else begin
      reqValid <= start;                                   // Single pulse
      ack      <= busy && done;
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy     <= 1'b0;
        readData <= allocDone ? allocResult : storeResult; // Only one side answers
      end
    end
  end

  // Address fields and operand held for the unit
  always_ff @(posedge clock) begin
    if (start) begin
      reqOp    <= heapPkg::heapOp'(adr[`HEAP_ADR_BITS-1 -: `HEAP_OP_BITS]);
      reqArray <= adr[`HEAP_INDEX_BITS +: `HEAP_ARRAY_BITS];
      reqIndex <= adr[`HEAP_INDEX_BITS-1:0];
      reqValue <= writeData;
    end
  end

endmodule

// File: logic/arrayAllocator.sv
//----------------------------------------------------------
// Array handle allocator
// Free-handle stack, fresh-handle counter, allocation flags
//----------------------------------------------------------
`timescale 1ns/1ns
`include "heapMemory_defs.svh"

module arrayAllocator (
  input  logic                         clock,
  input  logic                         reset,
  input  heapPkg::heapRequest          request,
  output logic [`HEAP_ARRAY_COUNT-1:0] allocated,
  output heapPkg::sizeClear            clearSizes,
  output heapPkg::heapResult           allocResult,
  output logic                         allocDone
);

  logic [`HEAP_ARRAY_BITS-1:0] freeStack [`HEAP_ARRAY_COUNT];
  logic [`HEAP_ARRAY_BITS:0]   stackTop;                   // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   stackBelow;
  logic [`HEAP_ARRAY_BITS:0]   nextHandle;                 // Next never-used handle
  logic                        isAllocOp;
  logic                        canReuse;
  logic                        canFresh;
  logic                        outOfMemory;
  logic                        freeOk;
  logic [`HEAP_ARRAY_BITS-1:0] newHandle;
  heapPkg::heapResult          nextResult;

  assign isAllocOp = request.valid && (request.op inside
                     {heapPkg::opClear, heapPkg::opAlloc, heapPkg::opFree});

  assign stackBelow  = stackTop - 1'b1;
  assign canReuse    = stackTop != '0;
  assign canFresh    = nextHandle < `HEAP_ARRAY_COUNT;
  assign outOfMemory = !canReuse && !canFresh;             // Every handle is in use
  assign freeOk      = allocated[request.array];
  assign newHandle   = canReuse ? freeStack[stackBelow[`HEAP_ARRAY_BITS-1:0]]
                                : nextHandle[`HEAP_ARRAY_BITS-1:0];

  // Result word of this request
  always_comb begin
    nextResult = '0;
    case (request.op)
      heapPkg::opAlloc: begin
        if (outOfMemory) begin
          nextResult.err = heapPkg::errOutOfMemory;
        end else begin
          nextResult.value = `HEAP_DATA_BITS'(newHandle);
        end
      end
      heapPkg::opFree: begin
        if (!freeOk) begin
          nextResult.err = heapPkg::errNotAllocated;
        end
      end
      default: ;                                           // Clear answers zero
    endcase
  end

  //----------------------------------------------------------
  // Flags, stack pointer and counter
  //----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocated  <= '0;
      stackTop   <= '0;
      nextHandle <= '0;
      clearSizes <= '0;
      allocDone  <= 1'b0;
    end else begin
      allocDone         <= isAllocOp;
      clearSizes.enable <= 1'b0;
      if (isAllocOp) begin
        case (request.op)
          heapPkg::opClear: begin
            allocated  <= '0;
            stackTop   <= '0;
            nextHandle <= '0;
            clearSizes <= '{enable: 1'b1, all: 1'b1, array: '0};
          end
          heapPkg::opAlloc: begin
            if (!outOfMemory) begin
              allocated[newHandle] <= 1'b1;
              clearSizes <= '{enable: 1'b1, all: 1'b0, array: newHandle}; // New array starts empty
              if (canReuse) begin
                stackTop <= stackBelow;                    // Last freed first
              end else begin
                nextHandle <= nextHandle + 1'b1;
              end
            end
          end
          heapPkg::opFree: begin
            if (freeOk) begin
              allocated[request.array] <= 1'b0;            // The freed handle's own flag
              stackTop <= stackTop + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Stack contents and result
  always_ff @(posedge clock) begin
    if (isAllocOp && request.op == heapPkg::opFree && freeOk) begin
      freeStack[stackTop[`HEAP_ARRAY_BITS-1:0]] <= request.array;
    end
    if (isAllocOp) begin
      allocResult <= nextResult;
    end
  end

endmodule

// File: logic/arrayStore.sv
//----------------------------------------------------------
// Element memory and size table of the heap arrays
// State and bounds checks, element operations
//----------------------------------------------------------
`timescale 1ns/1ns
`include "heapMemory_defs.svh"

module arrayStore (
  input  logic                         clock,
  input  logic                         reset,
  input  heapPkg::heapRequest          request,
  input  logic [`HEAP_ARRAY_COUNT-1:0] allocated,
  input  heapPkg::sizeClear            clearSizes,
  output heapPkg::heapResult           storeResult,
  output logic                         storeDone
);

  logic [`HEAP_DATA_BITS-1:0]  mem [`HEAP_ARRAY_COUNT][`HEAP_ARRAY_LENGTH];
  logic [`HEAP_INDEX_BITS:0]   sizes [`HEAP_ARRAY_COUNT];  // One bit wider than an index

  logic                        isStoreOp;
  logic [`HEAP_INDEX_BITS:0]   curSize;
  logic                        inBounds;
  logic [`HEAP_INDEX_BITS-1:0] topIndex;
  logic [`HEAP_DATA_BITS-1:0]  element;
  logic [`HEAP_DATA_BITS-1:0]  lastElement;
  logic [`HEAP_DATA_BITS-1:0]  sum;
  logic [`HEAP_INDEX_BITS:0]   matchPos;

  logic                        memWrite;
  logic [`HEAP_INDEX_BITS-1:0] memIndex;
  logic [`HEAP_DATA_BITS-1:0]  memData;
  logic                        sizeWrite;
  logic [`HEAP_INDEX_BITS:0]   newSize;
  heapPkg::heapResult          nextResult;

  // Everything the allocator does not take
  assign isStoreOp = request.valid && !(request.op inside
                     {heapPkg::opClear, heapPkg::opAlloc, heapPkg::opFree});

  assign curSize     = sizes[request.array];
  assign inBounds    = {1'b0, request.index} < curSize;
  assign topIndex    = curSize[`HEAP_INDEX_BITS-1:0] - 1'b1; // Wraps to 7 when full
  assign element     = mem[request.array][request.index];
  assign lastElement = mem[request.array][topIndex];
  assign sum         = element + request.value;           // Modulo 4096

  // Position after the last match inside the used part
  always_comb begin
    matchPos = '0;
    for (int i = 0; i < `HEAP_ARRAY_LENGTH; i++) begin
      if (i < curSize && mem[request.array][i] == request.value) begin
        matchPos = (`HEAP_INDEX_BITS + 1)'(i + 1);
      end
    end
  end

  //----------------------------------------------------------
  // Operation decode
  //----------------------------------------------------------
  always_comb begin
    nextResult = '0;
    memWrite   = 1'b0;
    memIndex   = request.index;
    memData    = request.value;
    sizeWrite  = 1'b0;
    newSize    = curSize;
    if (!allocated[request.array]) begin
      nextResult.err = heapPkg::errNotAllocated;           // Checked before any bounds
    end else begin
      case (request.op)
        heapPkg::opWrite: begin
          memWrite         = 1'b1;
          nextResult.value = request.value;
          if (!inBounds) begin
            sizeWrite = 1'b1;                              // Grow to cover the index
            newSize   = {1'b0, request.index} + 1'b1;
          end
        end
        heapPkg::opRead: begin
          if (inBounds) begin
            nextResult.value = element;
          end else begin
            nextResult.err = heapPkg::errOutOfBounds;
          end
        end
        heapPkg::opAdd: begin
          if (inBounds) begin
            memWrite         = 1'b1;
            memData          = sum;
            nextResult.value = sum;                        // New value
          end else begin
            nextResult.err = heapPkg::errOutOfBounds;
          end
        end
        heapPkg::opSize: begin
          nextResult.value = `HEAP_DATA_BITS'(curSize);
        end
        heapPkg::opPush: begin
          if (curSize == `HEAP_ARRAY_LENGTH) begin
            nextResult.err = heapPkg::errFull;
          end else begin
            memWrite         = 1'b1;
            memIndex         = curSize[`HEAP_INDEX_BITS-1:0];
            sizeWrite        = 1'b1;
            newSize          = curSize + 1'b1;
            nextResult.value = request.value;              // Echo of the pushed value
          end
        end
        heapPkg::opPop: begin
          if (curSize == '0) begin
            nextResult.err = heapPkg::errEmpty;
          end else begin
            sizeWrite        = 1'b1;
            newSize          = curSize - 1'b1;
            nextResult.value = lastElement;
          end
        end
        heapPkg::opIndexOf: begin
          nextResult.value = `HEAP_DATA_BITS'(matchPos);   // Zero when nothing matches
        end
        default: ;
      endcase
    end
  end

  //----------------------------------------------------------
  // Size table and done
  //----------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `HEAP_ARRAY_COUNT; i++) begin
        sizes[i] <= '0;
      end
      storeDone <= 1'b0;
    end else begin
      storeDone <= isStoreOp;
      if (isStoreOp && sizeWrite) begin
        sizes[request.array] <= newSize;
      end
      if (clearSizes.enable) begin
        if (clearSizes.all) begin
          for (int i = 0; i < `HEAP_ARRAY_COUNT; i++) begin
            sizes[i] <= '0;
          end
        end else begin
          sizes[clearSizes.array] <= '0;                   // Freshly allocated handle
        end
      end
    end
  end

  // Element memory and result
  always_ff @(posedge clock) begin
    if (isStoreOp && memWrite) begin
      mem[request.array][memIndex] <= memData;
    end
    if (isStoreOp) begin
      storeResult <= nextResult;
    end
  end

endmodule

// File: logic/heapMemory.sv
//----------------------------------------------------------
// Heap of small fixed-size arrays on a Wishbone slave port
// Bus port, handle allocator and element store
//----------------------------------------------------------
`timescale 1ns/1ns
`include "heapMemory_defs.svh"

module heapMemory (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`HEAP_ADR_BITS-1:0]  adr,
  input  logic [`HEAP_DATA_BITS-1:0] writeData,
  output logic                       ack,
  output heapPkg::heapResult         readData
);

  heapPkg::heapRequest          request;                   // To both units
  heapPkg::heapResult           allocResult;
  heapPkg::heapResult           storeResult;
  logic                         allocDone;
  logic                         storeDone;
  logic [`HEAP_ARRAY_COUNT-1:0] allocated;
  heapPkg::sizeClear            clearSizes;

  wbHeapPort port (
    .clock       (clock),
    .reset       (reset),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .writeData   (writeData),
    .allocResult (allocResult),
    .storeResult (storeResult),
    .allocDone   (allocDone),
    .storeDone   (storeDone),
    .request     (request),
    .ack         (ack),
    .readData    (readData)
  );

  arrayAllocator allocator (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .allocated   (allocated),
    .clearSizes  (clearSizes),
    .allocResult (allocResult),
    .allocDone   (allocDone)
  );

  arrayStore store (
    .clock       (clock),
    .reset       (reset),
    .request     (request),
    .allocated   (allocated),
    .clearSizes  (clearSizes),
    .storeResult (storeResult),
    .storeDone   (storeDone)
  );

endmodule

// File: verif/heapMemoryTb.sv
//----------------------------------------------------------
// Testbench of the heap memory
// Wishbone master, reference model, compare process,
// directed and random tests, watchdog
//----------------------------------------------------------
`timescale 1ns/1ns
`include "heapMemory_defs.svh"

module heapMemoryTb;

  localparam int directedOps = 60;
  localparam int randomOps   = 300;

  logic                       clock;
  logic                       reset;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [`HEAP_ADR_BITS-1:0]  adr;
  logic [`HEAP_DATA_BITS-1:0] writeData;
  logic                       ack;
  heapPkg::heapResult         readData;

  // Reference model state with elements unknown until written
  logic [`HEAP_DATA_BITS-1:0] modelMem [`HEAP_ARRAY_COUNT][`HEAP_ARRAY_LENGTH];
  int                         modelSize [`HEAP_ARRAY_COUNT];
  logic [`HEAP_ARRAY_COUNT-1:0] modelAlloc;
  int                         freeHandles [$];
  int                         nextFresh;

  heapPkg::heapResult         expectQ [$];                 // One entry per outstanding op
  heapPkg::heapResult         compareExpect;
  string                      testName;
  int                         errorCount;
  int                         errorsAtStart;
  int                         testsPassed;
  int                         testsFailed;

  heapMemory dut (
    .clock     (clock),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .writeData (writeData),
    .ack       (ack),
    .readData  (readData)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                             // 8 ns period
  end

  //----------------------------------------------------------
  // Reference model and helpers
  //----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic heapPkg::heapResult makeResult(input heapPkg::heapErr err, input int v);
    heapPkg::heapResult r;
    r.err   = err;
    r.spare = 1'b0;
    r.value = `HEAP_DATA_BITS'(v);
    return r;
  endfunction

  function automatic heapPkg::heapResult okResult(input int v);
    return makeResult(heapPkg::errNone, v);
  endfunction

  function automatic heapPkg::heapResult modelOp(input heapPkg::heapOp op, input int array,
                                                 input int index,
                                                 input logic [`HEAP_DATA_BITS-1:0] value);
    heapPkg::heapResult r;
    int handle;
    r = okResult(0);
    case (op)
      heapPkg::opClear: begin
        modelAlloc = '0;
        freeHandles.delete();
        nextFresh = 0;
        for (int i = 0; i < `HEAP_ARRAY_COUNT; i++) modelSize[i] = 0;
      end
      heapPkg::opAlloc: begin
        handle = -1;
        if (freeHandles.size() > 0) begin
          handle = freeHandles.pop_back();                 // Last freed comes back first
        end else if (nextFresh < `HEAP_ARRAY_COUNT) begin
          handle = nextFresh;
          nextFresh = nextFresh + 1;
        end
        if (handle < 0) begin
          r.err = heapPkg::errOutOfMemory;
        end else begin
          modelAlloc[handle] = 1'b1;
          modelSize[handle]  = 0;
          r.value = `HEAP_DATA_BITS'(handle);
        end
      end
      heapPkg::opFree: begin
        if (!modelAlloc[array]) begin
          r.err = heapPkg::errNotAllocated;
        end else begin
          modelAlloc[array] = 1'b0;
          freeHandles.push_back(array);
        end
      end
      default: begin
        if (!modelAlloc[array]) begin
          r.err = heapPkg::errNotAllocated;
        end else begin
          case (op)
            heapPkg::opWrite: begin
              modelMem[array][index] = value;
              if (index >= modelSize[array]) modelSize[array] = index + 1;
              r.value = value;
            end
            heapPkg::opRead: begin
              if (index < modelSize[array]) r.value = modelMem[array][index];
              else r.err = heapPkg::errOutOfBounds;
            end
            heapPkg::opAdd: begin
              if (index < modelSize[array]) begin
                modelMem[array][index] = modelMem[array][index] + value; // Wraps at 12 bits
                r.value = modelMem[array][index];
              end else begin
                r.err = heapPkg::errOutOfBounds;
              end
            end
            heapPkg::opSize: r.value = `HEAP_DATA_BITS'(modelSize[array]);
            heapPkg::opPush: begin
              if (modelSize[array] == `HEAP_ARRAY_LENGTH) begin
                r.err = heapPkg::errFull;
              end else begin
                modelMem[array][modelSize[array]] = value;
                modelSize[array] = modelSize[array] + 1;
                r.value = value;
              end
            end
            heapPkg::opPop: begin
              if (modelSize[array] == 0) begin
                r.err = heapPkg::errEmpty;
              end else begin
                modelSize[array] = modelSize[array] - 1;
                r.value = modelMem[array][modelSize[array]];
              end
            end
            heapPkg::opIndexOf: begin
              for (int i = 0; i < modelSize[array]; i++) begin
                if (modelMem[array][i] === value) r.value = `HEAP_DATA_BITS'(i + 1);
              end
            end
            default: ;
          endcase
        end
      end
    endcase
    return r;
  endfunction

  //----------------------------------------------------------
  // Compare tasks and test bookkeeping
  //----------------------------------------------------------
  task automatic checkResult(input string name, input heapPkg::heapResult expected,
                             input heapPkg::heapResult actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected err=%s value=%h, actual err=%s value=%h", name,
               expected.err.name(), expected.value, actual.err.name(), actual.value);
      errorCount++;
    end
  endtask

  task automatic checkErr(input string name, input heapPkg::heapErr expected,
                          input heapPkg::heapErr actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected err=%s, actual err=%s", name, expected.name(),
               actual.name());
      errorCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic finishTest();
    if (errorCount == errorsAtStart) begin
      $display("test %-12s ok", testName);
      testsPassed++;
    end else begin
      $display("test %-12s %0d errors", testName, errorCount - errorsAtStart);
      testsFailed++;
    end
  endtask

  // Bus master started 1 ns after a rising edge
  task automatic runOp(input heapPkg::heapOp op, input int array, input int index,
                       input logic [`HEAP_DATA_BITS-1:0] value,
                       output heapPkg::heapResult result);
    int waited;
    expectQ.push_back(modelOp(op, array, index, value));
    cyc       = 1'b1;
    stb       = 1'b1;
    we        = op inside {heapPkg::opWrite, heapPkg::opPush, heapPkg::opAdd};
    adr       = {op, `HEAP_ARRAY_BITS'(array), `HEAP_INDEX_BITS'(index)};
    writeData = value;
    @(posedge clock);                                      // Slave samples stb here
    waited = 0;
    do begin
      @(posedge clock);
      #1;
      waited++;
    end while (!ack && waited < 10);
    if (!ack) begin
      $display("%s: no ack from the DUT within 10 cycles", testName);
      errorCount++;
      void'(expectQ.pop_back());
    end else if (waited != 2) begin
      $display("%s: ack latency was %0d cycles instead of 2", testName, waited);
      errorCount++;
    end
    result = readData;
    cyc    = 1'b0;
    stb    = 1'b0;
    @(posedge clock);                                      // Let ack fall
    #1;
  endtask

  // Every ack against the model
  always @(negedge clock) begin
    if (reset && ack) begin
      if (expectQ.size() == 0) begin
        $display("%s: ack with no operation outstanding", testName);
        errorCount++;
      end else begin
        compareExpect = expectQ.pop_front();
        checkResult(testName, compareExpect, readData);
      end
    end
  end

  initial begin
    repeat ((directedOps + randomOps) * 10 + 100) @(posedge clock);
    $display("Watchdog: simulation timed out");
    $display("TEST FAILED");
    $finish;
  end

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------
  initial begin
    heapPkg::heapResult got;
    heapPkg::heapOp     op;
    logic [31:0]        rng;
    logic [`HEAP_DATA_BITS-1:0] value;
    reset = 1'b0;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    writeData = '0;
    modelAlloc = '0;
    nextFresh = 0;
    errorCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    testName = "reset";
    for (int i = 0; i < `HEAP_ARRAY_COUNT; i++) modelSize[i] = 0;
    repeat (3) @(posedge clock);
    #1 reset = 1'b1;
    @(posedge clock);
    #1;

    startTest("allocPush");
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    checkResult(testName, okResult(0), got);
    runOp(heapPkg::opPush, 0, 0, 1, got);
    runOp(heapPkg::opPush, 0, 0, 2, got);
    runOp(heapPkg::opSize, 0, 0, 0, got);
    checkResult(testName, okResult(2), got);
    runOp(heapPkg::opRead, 0, 0, 0, got);
    checkResult(testName, okResult(1), got);
    runOp(heapPkg::opRead, 0, 1, 0, got);
    checkResult(testName, okResult(2), got);
    finishTest();

    startTest("allocRules");
    runOp(heapPkg::opClear, 0, 0, 0, got);
    for (int h = 0; h < 4; h++) begin
      runOp(heapPkg::opAlloc, 0, 0, 0, got);
      checkResult(testName, okResult(h), got);             // Fresh handles count up
    end
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    checkErr(testName, heapPkg::errOutOfMemory, got.err);
    runOp(heapPkg::opFree, 2, 0, 0, got);
    checkErr(testName, heapPkg::errNone, got.err);
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    checkResult(testName, okResult(2), got);
    runOp(heapPkg::opClear, 0, 0, 0, got);
    runOp(heapPkg::opFree, 1, 0, 0, got);
    checkErr(testName, heapPkg::errNotAllocated, got.err);
    finishTest();

    startTest("bounds");
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    runOp(heapPkg::opRead, 0, 0, 0, got);
    checkErr(testName, heapPkg::errOutOfBounds, got.err);
    for (int n = 1; n <= 9; n++) begin
      runOp(heapPkg::opPush, 0, 0, n * 3, got);
      checkErr(testName, (n == 9) ? heapPkg::errFull : heapPkg::errNone, got.err);
    end
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    runOp(heapPkg::opPop, 1, 0, 0, got);
    checkErr(testName, heapPkg::errEmpty, got.err);
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    runOp(heapPkg::opWrite, 2, 5, 12'h5a5, got);
    runOp(heapPkg::opSize, 2, 0, 0, got);
    checkResult(testName, okResult(6), got);
    finishTest();

    startTest("elementOps");
    runOp(heapPkg::opClear, 0, 0, 0, got);
    runOp(heapPkg::opAlloc, 0, 0, 0, got);
    runOp(heapPkg::opWrite, 0, 0, 4000, got);
    checkResult(testName, okResult(4000), got);
    runOp(heapPkg::opAdd, 0, 0, 200, got);
    checkResult(testName, okResult(104), got);             // 4200 wraps past 4096
    runOp(heapPkg::opPush, 0, 0, 7, got);
    runOp(heapPkg::opPush, 0, 0, 7, got);
    runOp(heapPkg::opPush, 0, 0, 9, got);
    runOp(heapPkg::opIndexOf, 0, 0, 7, got);
    checkResult(testName, okResult(3), got);
    runOp(heapPkg::opIndexOf, 0, 0, 55, got);
    checkResult(testName, okResult(0), got);
    runOp(heapPkg::opPop, 0, 0, 0, got);
    checkResult(testName, okResult(9), got);
    runOp(heapPkg::opPop, 0, 0, 0, got);
    checkResult(testName, okResult(7), got);
    finishTest();

    startTest("random");
    rng = 32'd97;
    runOp(heapPkg::opClear, 0, 0, 0, got);
    for (int n = 0; n < randomOps; n++) begin
      rng = xorshift(rng);
      op  = heapPkg::heapOp'(`HEAP_OP_BITS'(rng % 10));
      if (op == heapPkg::opClear && rng[31:30] != 2'd0) begin
        op = heapPkg::opAlloc;                             // Keep clears rare
      end
      value = rng[13] ? rng[25:14] : {9'd0, rng[28:26]};   // Small values match often
      runOp(op, rng[9:8], rng[12:10], value, got);
    end
    finishTest();

    $display("passed tests: %0d, failed tests: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
logic/heapPkg.sv
logic/wbHeapPort.sv
logic/arrayAllocator.sv
logic/arrayStore.sv
logic/heapMemory.sv
verif/heapMemoryTb.sv
